/* Bender.yml */
package:
  name: cp0

sources:
  - logic/cp0_pkg.sv
  - logic/exc_pkg.sv
  - logic/cp0_status_reg.sv
  - logic/cp0_cause_reg.sv
  - logic/cp0_exc_addr_regs.sv
  - logic/cp0_timer.sv
  - logic/cp0.sv
  - target: test
    files:
      - dv/cp0_chk.sv
      - dv/cp0_tb.sv

/* dv/cp0_chk.sv */
module cp0_chk (
    input  logic               clk,
    input  logic               arst_n,
    input  exc_pkg::wb_req_t   wb,
    input  cp0_pkg::status_u   status,
    input  cp0_pkg::cause_u    cause,
    input  exc_pkg::redirect_t redirect
);

    int   fail_count = 0;
    logic int_req;
    logic exc_entry;

    // interrupt request from the architectural fields
    assign int_req   = (|(cause.f.ip & status.f.im)) && status.f.ie && !status.f.exl;
    // retiring instruction that must enter the handler
    assign exc_entry = wb.valid && (wb.exc || int_req);

    // ------------------------------------------------------------------
    // redirect
    // ------------------------------------------------------------------
    // flush only ever rides on a retiring instruction with a reason
    flush_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.flush |-> (wb.valid && (wb.exc || wb.eret || int_req))
    ) else begin
        $error("flush raised with no valid writeback instruction");
        fail_count++;
    end

    // exception entry always fetches from the vector
    take_targets_vector: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc_entry |-> (redirect.flush && (redirect.target == exc_pkg::EXC_VECTOR))
    ) else begin
        $error("exception redirect does not point at the exception vector");
        fail_count++;
    end

    // ------------------------------------------------------------------
    // status.exl
    // ------------------------------------------------------------------
    take_sets_exl: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc_entry |=> status.f.exl
    ) else begin
        $error("exl not set in the cycle after an exception");
        fail_count++;
    end

    // plain eret, nothing pending
    eret_clears_exl: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb.valid && wb.eret && !exc_entry) |=> !status.f.exl
    ) else begin
        $error("exl still set in the cycle after eret");
        fail_count++;
    end

endmodule

bind cp0 cp0_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb       (wb),
    .status   (status),
    .cause    (cause),
    .redirect (redirect)
);

/* dv/cp0_tb.sv */
module cp0_tb;

    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'h0a15_81fc;
    // iterations per test
    localparam int          N_RT         = 40;
    localparam int          N_EXC        = 30;
    localparam int          N_ERET       = 10;
    localparam int          N_INT        = 30;
    localparam int          N_TIM        = 8;
    localparam int          TIM_READS    = 16;
    localparam int          TAIL         = 3;
    // cycles driven by each test, quiesce is 3
    localparam int          STIM_CYCLES  = N_RT * 2 + (3 + N_EXC * 6) + (3 + N_ERET * 6)
                                         + N_INT * 10 + 3 + N_TIM * (9 + TIM_READS) + TAIL;
    localparam int          WATCHDOG     = RESET_CYCLES + STIM_CYCLES + 200;

    typedef struct packed {
        logic [31:0]        rdata;
        exc_pkg::redirect_t redirect;
    } expect_t;

    logic               clk;
    logic               arst_n;
    exc_pkg::wb_req_t   wb;
    logic [5:0]         ext_int;
    logic [31:0]        rdata;
    exc_pkg::redirect_t redirect;

    logic [5:0]         ext_level;
    string              test_name;
    expect_t            expected;

    // model state, value after the coming edge once stepped
    logic [31:0]        m_status;
    logic [1:0]         m_ip_sw;
    logic [5:0]         m_ext;
    logic               m_ti;
    logic               m_bd;
    logic [4:0]         m_code;
    logic [31:0]        m_epc;
    logic [31:0]        m_bad;
    logic [31:0]        m_count;
    logic [31:0]        m_compare;
    logic               m_phase;

    cp0 uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb),
        .ext_int  (ext_int),
        .rdata    (rdata),
        .redirect (redirect)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic void model_reset();
        m_status  = 32'h0000_0002;
        m_ip_sw   = '0;
        m_ext     = '0;
        m_ti      = 1'b0;
        m_bd      = 1'b0;
        m_code    = '0;
        m_epc     = '0;
        m_bad     = '0;
        m_count   = '0;
        m_compare = '0;
        m_phase   = 1'b0;
    endfunction

    // outputs for this request, then advance one cycle
    function automatic expect_t ref_model(input exc_pkg::wb_req_t req, input logic [5:0] ext);
        expect_t    e;
        logic [7:0] ip;
        logic       old_exl;
        logic       pend;
        logic       tk;
        logic       er;
        logic       we;
        logic       hit;
        logic [4:0] code;

        ip      = {m_ext[5] | m_ti, m_ext[4:0], m_ip_sw};
        old_exl = m_status[1];
        // ip & im, ie set, exl clear
        pend    = (|(ip & m_status[15:8])) && m_status[0] && !old_exl;
        tk      = req.valid && (pend || req.exc);
        er      = req.valid && req.eret && !tk;
        we      = req.valid && req.mtc0 && !tk;
        code    = pend ? exc_pkg::EXC_INT : req.exc_code;

        case (req.addr)
            cp0_pkg::ADDR_BADVADDR: e.rdata = m_bad;
            cp0_pkg::ADDR_COUNT:    e.rdata = m_count;
            cp0_pkg::ADDR_COMPARE:  e.rdata = m_compare;
            cp0_pkg::ADDR_STATUS:   e.rdata = m_status;
            cp0_pkg::ADDR_CAUSE:    e.rdata = {m_bd, m_ti, 14'd0, ip, 1'b0, m_code, 2'b00};
            cp0_pkg::ADDR_EPC:      e.rdata = m_epc;
            default:                e.rdata = '0;
        endcase
        e.redirect.flush  = tk || er;
        e.redirect.target = tk ? exc_pkg::EXC_VECTOR : m_epc;

        // tick on phase, match seen before count moves
        hit = m_phase && (m_count == m_compare);
        if (we && req.addr == cp0_pkg::ADDR_COMPARE) begin
            m_ti = 1'b0;
        end else if (hit) begin
            m_ti = 1'b1;
        end
        m_ext = ext;
        if (we && req.addr == cp0_pkg::ADDR_CAUSE) begin
            m_ip_sw = req.wdata[9:8];
        end
        if (tk) begin
            m_code = code;
            // nested fault keeps bd and epc
            if (!old_exl) begin
                m_bd  = req.bd;
                m_epc = req.bd ? req.pc - 32'd4 : req.pc;
            end
            if (code == exc_pkg::EXC_ADEL || code == exc_pkg::EXC_ADES) begin
                m_bad = req.bad_vaddr;
            end
        end else if (we && req.addr == cp0_pkg::ADDR_EPC) begin
            m_epc = req.wdata;
        end
        // im, exl and ie writable
        if (we && req.addr == cp0_pkg::ADDR_STATUS) begin
            m_status = req.wdata & 32'h0000_ff03;
        end
        if (tk) begin
            m_status[1] = 1'b1;
        end else if (er) begin
            m_status[1] = 1'b0;
        end
        if (we && req.addr == cp0_pkg::ADDR_COUNT) begin
            m_count = req.wdata;
            m_phase = 1'b1;
        end else begin
            m_count = m_count + {31'd0, m_phase};
            m_phase = ~m_phase;
        end
        if (we && req.addr == cp0_pkg::ADDR_COMPARE) begin
            m_compare = req.wdata;
        end
        return e;
    endfunction

    // ------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------
    task automatic check_value(input string tag, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s (%s) expected %0h actual %0h", test_name, tag, exp, act);
            $display("Simulation FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // inputs settle after the rising edge, sample at the falling one
    always @(negedge clk) begin
        if (!arst_n) begin
            model_reset();
        end else begin
            expected = ref_model(wb, ext_int);
            check_value("rdata", 64'(expected.rdata), 64'(rdata));
            check_value("redirect", 64'(expected.redirect), 64'(redirect));
            // failures from the bound checker
            if (uut.u_chk.fail_count != 0) begin
                $display("assertion in the bound checker failed during %s", test_name);
                $display("Simulation FAILED");
                $fatal(1, "stopping at first error");
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------
    function automatic exc_pkg::wb_req_t plain_req(input logic valid, input logic [4:0] addr);
        exc_pkg::wb_req_t r;
        r       = '0;
        r.valid = valid;
        r.pc    = $urandom() & 32'hffff_fffc;
        r.addr  = addr;
        return r;
    endfunction

    function automatic logic [4:0] pick_code();
        case ($urandom() % 6)
            0:       return exc_pkg::EXC_ADEL;
            1:       return exc_pkg::EXC_ADES;
            2:       return exc_pkg::EXC_SYS;
            3:       return exc_pkg::EXC_BP;
            4:       return exc_pkg::EXC_RI;
            default: return exc_pkg::EXC_OV;
        endcase
    endfunction

    task automatic drive(input exc_pkg::wb_req_t r);
        @(posedge clk);
        wb      <= r;
        ext_int <= ext_level;
    endtask

    task automatic read_reg(input logic [4:0] addr);
        drive(plain_req(1'b1, addr));
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        exc_pkg::wb_req_t r;
        r       = plain_req(1'b1, addr);
        r.mtc0  = 1'b1;
        r.wdata = data;
        drive(r);
    endtask

    // junk fields with valid low, must do nothing
    task automatic idle_cycle(input logic [4:0] addr);
        exc_pkg::wb_req_t r;
        r       = plain_req(1'b0, addr);
        r.exc   = 1'($urandom() % 2);
        r.eret  = 1'($urandom() % 2);
        r.mtc0  = 1'b1;
        r.wdata = $urandom();
        drive(r);
    endtask

    task automatic fault(input logic [4:0] code, input logic bd);
        exc_pkg::wb_req_t r;
        r           = plain_req(1'b1, 5'd8 + 5'($urandom() % 7));
        r.exc       = 1'b1;
        r.exc_code  = code;
        r.bd        = bd;
        r.bad_vaddr = $urandom();
        // carried mtc0 is dropped by the fault
        r.mtc0      = 1'b1;
        r.wdata     = $urandom();
        drive(r);
    endtask

    task automatic return_from_exc();
        exc_pkg::wb_req_t r;
        r      = plain_req(1'b1, cp0_pkg::ADDR_EPC);
        r.eret = 1'b1;
        drive(r);
    endtask

    // first valid op absorbs any pending interrupt
    task automatic quiesce();
        read_reg(cp0_pkg::ADDR_STATUS);
        write_reg(cp0_pkg::ADDR_CAUSE, 32'd0);
        write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    initial begin
        logic [4:0]  addr;
        logic [31:0] data;
        logic [31:0] base;
        int          k;

        clk       = 1'b0;
        arst_n    = 1'b0;
        wb        = '0;
        ext_int   = '0;
        ext_level = '0;
        test_name = "reset";
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        test_name = "mtc0_mfc0";
        for (int i = 0; i < N_RT; i++) begin
            addr = 5'($urandom() % 16);
            data = $urandom();
            // keep ie low so writes are not swallowed by interrupts
            if (addr == cp0_pkg::ADDR_STATUS) begin
                data[0] = 1'b0;
            end
            write_reg(addr, data);
            read_reg(addr);
        end

        test_name = "sync_exc";
        quiesce();
        for (int i = 0; i < N_EXC; i++) begin
            fault(pick_code(), 1'($urandom() % 2));
            read_reg(cp0_pkg::ADDR_EPC);
            read_reg(cp0_pkg::ADDR_CAUSE);
            read_reg(cp0_pkg::ADDR_BADVADDR);
            read_reg(cp0_pkg::ADDR_STATUS);
            return_from_exc();
        end

        test_name = "eret_nested";
        quiesce();
        for (int i = 0; i < N_ERET; i++) begin
            write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
            fault(pick_code(), 1'($urandom() % 2));
            // second fault with exl set
            fault(pick_code(), 1'($urandom() % 2));
            read_reg(cp0_pkg::ADDR_EPC);
            return_from_exc();
            read_reg(cp0_pkg::ADDR_STATUS);
        end

        test_name = "interrupts";
        for (int i = 0; i < N_INT; i++) begin
            data = {16'd0, 8'($urandom()), 6'd0, 1'(($urandom() % 4) == 0),
                    1'(($urandom() % 4) != 0)};
            write_reg(cp0_pkg::ADDR_STATUS, data);
            write_reg(cp0_pkg::ADDR_CAUSE, 32'($urandom() % 4) << 8);
            ext_level = (($urandom() % 2) == 0) ? 6'($urandom()) : 6'd0;
            idle_cycle(cp0_pkg::ADDR_CAUSE);
            idle_cycle(cp0_pkg::ADDR_STATUS);
            read_reg(cp0_pkg::ADDR_STATUS);
            read_reg(cp0_pkg::ADDR_CAUSE);
            return_from_exc();
            ext_level = '0;
            read_reg(cp0_pkg::ADDR_EPC);
            write_reg(cp0_pkg::ADDR_CAUSE, 32'd0);
            write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
        end

        test_name = "timer";
        quiesce();
        for (int i = 0; i < N_TIM; i++) begin
            base = $urandom();
            k    = 1 + int'($urandom() % 6);
            write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
            write_reg(cp0_pkg::ADDR_COUNT, base);
            write_reg(cp0_pkg::ADDR_COMPARE, base + 32'(k));
            // ti watched cycle by cycle
            repeat (TIM_READS) read_reg(cp0_pkg::ADDR_CAUSE);
            // im[7] and ie, exl clear
            write_reg(cp0_pkg::ADDR_STATUS, 32'h0000_8001);
            read_reg(cp0_pkg::ADDR_STATUS);
            read_reg(cp0_pkg::ADDR_CAUSE);
            write_reg(cp0_pkg::ADDR_COMPARE, base);
            write_reg(cp0_pkg::ADDR_STATUS, 32'd0);
            read_reg(cp0_pkg::ADDR_CAUSE);
        end

        test_name = "drain";
        repeat (TAIL) idle_cycle(5'd0);
        @(posedge clk);
        if (uut.u_chk.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* logic/cp0.sv */
module cp0 (
    input  logic               clk,
    input  logic               arst_n,
    input  exc_pkg::wb_req_t   wb,
    input  logic [5:0]         ext_int,
    output logic [31:0]        rdata,
    output exc_pkg::redirect_t redirect
);

    cp0_pkg::status_u  status;
    cp0_pkg::cause_u   cause;
    cp0_pkg::cp0_wr_t  wr;
    exc_pkg::exc_evt_t evt;
    logic [31:0]       epc;
    logic [31:0]       bad_vaddr;
    logic [31:0]       count;
    logic [31:0]       compare;
    logic              timer_hit;
    logic              compare_wr;
    logic              int_pending;
    logic              take;

    // ------------------------------------------------------------------
    // event resolution
    // ------------------------------------------------------------------
    // unmasked line, ints enabled, not already in a handler
    assign int_pending = (|(cause.f.ip & status.f.im)) && status.f.ie && !status.f.exl;

    // interrupts ride on a retiring instruction
    assign take = wb.valid && (int_pending || wb.exc);

    always_comb begin
        evt.take      = take;
        evt.eret      = wb.valid && wb.eret && !take;
        // interrupt beats the instruction's own fault
        evt.code      = int_pending ? exc_pkg::EXC_INT : wb.exc_code;
        evt.bd        = wb.bd;
        evt.pc        = wb.pc;
        evt.bad_vaddr = wb.bad_vaddr;
    end

    // a faulting mtc0 never commits
    always_comb begin
        wr.we   = wb.valid && wb.mtc0 && !take;
        wr.addr = wb.addr;
        wr.data = wb.wdata;
    end

    cp0_status_reg u_status (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr),
        .evt    (evt),
        .status (status)
    );

    cp0_cause_reg u_cause (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr         (wr),
        .evt        (evt),
        .ext_int    (ext_int),
        .timer_hit  (timer_hit),
        .compare_wr (compare_wr),
        .status_exl (status.f.exl),
        .cause      (cause)
    );

    cp0_exc_addr_regs u_exc_addr (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr         (wr),
        .evt        (evt),
        .status_exl (status.f.exl),
        .epc        (epc),
        .bad_vaddr  (bad_vaddr)
    );

    cp0_timer u_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr         (wr),
        .count      (count),
        .compare    (compare),
        .timer_hit  (timer_hit),
        .compare_wr (compare_wr)
    );

    // ------------------------------------------------------------------
    // mfc0 read and redirect
    // ------------------------------------------------------------------
    always_comb begin
        case (wb.addr)
            cp0_pkg::ADDR_BADVADDR: rdata = bad_vaddr;
            cp0_pkg::ADDR_COUNT:    rdata = count;
            cp0_pkg::ADDR_COMPARE:  rdata = compare;
            cp0_pkg::ADDR_STATUS:   rdata = status.raw;
            cp0_pkg::ADDR_CAUSE:    rdata = cause.raw;
            cp0_pkg::ADDR_EPC:      rdata = epc;
            // unmapped numbers
            default:                rdata = '0;
        endcase
    end

    // eret returns through the current epc
    assign redirect.flush  = take || evt.eret;
    assign redirect.target = take ? exc_pkg::EXC_VECTOR : epc;

endmodule

/* logic/cp0_cause_reg.sv */
module cp0_cause_reg (
    input  logic              clk,
    input  logic              arst_n,
    input  cp0_pkg::cp0_wr_t  wr,
    input  exc_pkg::exc_evt_t evt,
    input  logic [5:0]        ext_int,
    input  logic              timer_hit,
    input  logic              compare_wr,
    input  logic              status_exl,
    output cp0_pkg::cause_u   cause
);

    logic            cause_wr;
    cp0_pkg::cause_u wr_view;
    // hardware interrupt lines, one flop of sampling
    logic [5:0]      ext_q;
    logic            ti_q;
    logic [1:0]      ip_sw_q;
    logic            bd_q;
    logic [4:0]      exc_code_q;

    assign cause_wr = wr.we && (wr.addr == cp0_pkg::ADDR_CAUSE);

    // masked write data seen through the field layout
    always_comb begin
        wr_view.raw = wr.data & cp0_pkg::CAUSE_WMASK;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_q      <= '0;
            ti_q       <= 1'b0;
            ip_sw_q    <= '0;
            bd_q       <= 1'b0;
            exc_code_q <= '0;
        end else begin
            ext_q <= ext_int;
            // sticky timer flag, acked by rewriting compare
            if (compare_wr) begin
                ti_q <= 1'b0;
            end else if (timer_hit) begin
                ti_q <= 1'b1;
            end
            if (cause_wr) begin
                ip_sw_q <= wr_view.f.ip[1:0];
            end
            // exccode always follows the event
            // bd only on a first-level exception
            if (evt.take) begin
                exc_code_q <= evt.code;
                if (!status_exl) begin
                    bd_q <= evt.bd;
                end
            end
        end
    end

    // ip7 shares the timer with hw line 5
    always_comb begin
        cause.raw        = '0;
        cause.f.bd       = bd_q;
        cause.f.ti       = ti_q;
        cause.f.ip       = {ext_q[5] | ti_q, ext_q[4:0], ip_sw_q};
        cause.f.exc_code = exc_code_q;
    end

endmodule

/* logic/cp0_exc_addr_regs.sv */
module cp0_exc_addr_regs (
    input  logic              clk,
    input  logic              arst_n,
    input  cp0_pkg::cp0_wr_t  wr,
    input  exc_pkg::exc_evt_t evt,
    input  logic              status_exl,
    output logic [31:0]       epc,
    output logic [31:0]       bad_vaddr
);

    logic epc_wr;
    logic capture_epc;
    logic capture_bad;

    assign epc_wr = wr.we && (wr.addr == cp0_pkg::ADDR_EPC);

    // nested exception keeps the original return address
    assign capture_epc = evt.take && !status_exl;

    // address errors only
    assign capture_bad = evt.take && ((evt.code == exc_pkg::EXC_ADEL) ||
                                      (evt.code == exc_pkg::EXC_ADES));

    // ------------------------------------------------------------------
    // epc
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            epc <= '0;
        end else if (capture_epc) begin
            // delay slot: return to the branch
            epc <= evt.bd ? evt.pc - 32'd4 : evt.pc;
        end else if (epc_wr) begin
            epc <= wr.data;
        end
    end

    // badvaddr, no software write path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bad_vaddr <= '0;
        end else if (capture_bad) begin
            bad_vaddr <= evt.bad_vaddr;
        end
    end

endmodule

/* logic/cp0_pkg.sv */
package cp0_pkg;

    // ------------------------------------------------------------------
    // register numbers, select 0 only
    // ------------------------------------------------------------------
    localparam logic [4:0] ADDR_BADVADDR = 5'd8;
    localparam logic [4:0] ADDR_COUNT    = 5'd9;
    localparam logic [4:0] ADDR_COMPARE  = 5'd11;
    localparam logic [4:0] ADDR_STATUS   = 5'd12;
    localparam logic [4:0] ADDR_CAUSE    = 5'd13;
    localparam logic [4:0] ADDR_EPC      = 5'd14;

    // software-writable bits
    // status: im, exl, ie
    localparam logic [31:0] STATUS_WMASK = 32'h0000_ff03;
    // cause: only the two software interrupt bits ip[1:0]
    localparam logic [31:0] CAUSE_WMASK  = 32'h0000_0300;
    // exl comes up set, all else clear
    localparam logic [31:0] STATUS_RESET = 32'h0000_0002;

    // mtc0 command, fanned out to every register block
    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    // ------------------------------------------------------------------
    // field layouts
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  im;        // 15:8
        logic [5:0]  zero_lo;
        logic        exl;       // 1
        logic        ie;        // 0
    } status_t;

    typedef union packed {
        logic [31:0] raw;
        status_t     f;
    } status_u;

    typedef struct packed {
        logic        bd;        // 31
        logic        ti;        // 30
        logic [13:0] zero_hi;
        logic [7:0]  ip;        // 15:8
        logic        zero_mid;
        logic [4:0]  exc_code;  // 6:2
        logic [1:0]  zero_lo;
    } cause_t;

    typedef union packed {
        logic [31:0] raw;
        cause_t      f;
    } cause_u;

endpackage

/* logic/cp0_status_reg.sv */
module cp0_status_reg (
    input  logic              clk,
    input  logic              arst_n,
    input  cp0_pkg::cp0_wr_t  wr,
    input  exc_pkg::exc_evt_t evt,
    output cp0_pkg::status_u  status
);

    logic             wr_hit;
    cp0_pkg::status_u status_d;

    assign wr_hit = wr.we && (wr.addr == cp0_pkg::ADDR_STATUS);

    // next value
    // mtc0 first, then exception entry / eret on exl
    always_comb begin
        status_d = status;
        if (wr_hit) begin
            status_d.raw = wr.data & cp0_pkg::STATUS_WMASK;
        end
        // entering the handler
        if (evt.take) begin
            status_d.f.exl = 1'b1;
        // leaving it
        end else if (evt.eret) begin
            status_d.f.exl = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status.raw <= cp0_pkg::STATUS_RESET;
        end else begin
            status <= status_d;
        end
    end

endmodule

/* logic/cp0_timer.sv */
module cp0_timer (
    input  logic             clk,
    input  logic             arst_n,
    input  cp0_pkg::cp0_wr_t wr,
    output logic [31:0]      count,
    output logic [31:0]      compare,
    output logic             timer_hit,
    output logic             compare_wr
);

    // high on cycles where count advances
    logic phase_q;
    logic count_wr;

    assign count_wr   = wr.we && (wr.addr == cp0_pkg::ADDR_COUNT);
    assign compare_wr = wr.we && (wr.addr == cp0_pkg::ADDR_COMPARE);

    // ------------------------------------------------------------------
    // count, half core rate
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= 1'b0;
            count   <= '0;
        end else if (count_wr) begin
            // written value holds one cycle, then steps
            count   <= wr.data;
            phase_q <= 1'b1;
        end else begin
            count   <= count + {31'd0, phase_q};
            phase_q <= ~phase_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            compare <= '0;
        end else if (compare_wr) begin
            compare <= wr.data;
        end
    end

    // match only counts on a tick
    // cause latches it as ti
    assign timer_hit = phase_q && (count == compare);

endmodule

/* logic/exc_pkg.sv */
package exc_pkg;

    // ------------------------------------------------------------------
    // exception codes, cause.exccode encoding
    // ------------------------------------------------------------------
    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    // general exception entry, bev = 1
    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

    // instruction retiring at writeback
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        bd;        // sits in a branch delay slot
        logic        exc;       // earlier stage flagged an exception
        logic [4:0]  exc_code;
        logic        eret;
        logic        mtc0;
        logic [4:0]  addr;      // cp0 register number, mtc0 and mfc0
        logic [31:0] wdata;
        logic [31:0] bad_vaddr;
    } wb_req_t;

    // resolved event, one per cycle at most
    typedef struct packed {
        logic        take;
        logic        eret;
        logic [4:0]  code;
        logic        bd;
        logic [31:0] pc;
        logic [31:0] bad_vaddr;
    } exc_evt_t;

    // front end flush and new fetch address
    typedef struct packed {
        logic        flush;
        logic [31:0] target;
    } redirect_t;

endpackage

/* project.f */
logic/cp0_pkg.sv
logic/exc_pkg.sv
logic/cp0_status_reg.sv
logic/cp0_cause_reg.sv
logic/cp0_exc_addr_regs.sv
logic/cp0_timer.sv
logic/cp0.sv
dv/cp0_chk.sv
dv/cp0_tb.sv
